/* exc_ctrl_top.f */
+incdir+verilog
verilog/exc_pkg.sv
verilog/csr_regfile.sv
verilog/pipeline_ctrl.sv
verilog/pc_gen.sv
verilog/exc_ctrl_top.sv
tests/tb_exc_ctrl.sv

/* Makefile */
TOP = tb_exc_ctrl
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f exc_ctrl_top.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_exc_ctrl.sv */
`default_nettype none

`include "exc_params.svh"

module tb_exc_ctrl;

    localparam int NUM_CYCLES = 4000;

    logic                   clk;
    logic                   reset_i;
    exc_pkg::pause_req_t    pause_req;
    exc_pkg::mem_ctrl_t     mem;
    exc_pkg::csr_write_t    wb_fwd;
    logic [`HW_IRQ_W-1:0]   hw_irq;
    logic [`CSR_ADDR_W-1:0] csr_raddr;
    exc_pkg::ctrl_t         ctrl;
    logic [31:0]            pc;
    logic [31:0]            csr_rdata;

    integer seed;
    int     addr_idx;
    int     ctrl_errs = 0;
    int     pc_errs = 0;
    int     csr_errs = 0;
    int     n_exc = 0;
    int     n_ertn = 0;

    logic [`CSR_ADDR_W-1:0] csr_addrs [6] = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG,
                                              `CSR_ESTAT, `CSR_ERA, `CSR_EENTRY};

    // model of the csr state and fetch pc.
    logic [1:0]           m_plv, m_pplv, m_sw;
    logic                 m_ie, m_pie;
    logic [`INT_BITS-1:0] m_lie;
    logic [`HW_IRQ_W-1:0] m_hw;
    logic [`ECODE_W-1:0]  m_ecode;
    logic [31:0]          m_era, m_eentry, m_pc;

    exc_pkg::ctrl_t       e_ctrl;
    logic                 e_exc;
    logic                 e_ertn;
    logic [`ECODE_W-1:0]  e_ecode;

    exc_ctrl_top dut_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .pause_req_i (pause_req),
        .mem_i       (mem),
        .wb_fwd_i    (wb_fwd),
        .hw_irq_i    (hw_irq),
        .csr_raddr_i (csr_raddr),
        .ctrl_o      (ctrl),
        .pc_o        (pc),
        .csr_rdata_o (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ******************************
    // random stimulus
    // ******************************
    task automatic drive_random();
        logic [31:0]         r;
        logic [31:0]         r2;
        logic [31:0]         r3;
        logic [31:0]         r4;
        exc_pkg::mem_ctrl_t  m;
        exc_pkg::csr_write_t w;
        r  = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        r4 = $random(seed);
        pause_req <= r[3:0] & r[7:4] & r[11:8];  // each request about 1 in 8.
        m.valid     = (r[13:12] != 2'b00);
        m.pc        = {r2[31:2], 2'b00};
        m.exc_valid = (r[15:14] == 2'b00) ? r[21:16] : 6'b0;
        m.exc_cause = {r3, r2[3:0]};
        m.is_ertn   = (r[23:22] == 2'b00);
        m.is_idle   = (r[25:24] == 2'b00);
        mem <= m;
        w.en       = (r[27:26] == 2'b00);
        w.addr     = csr_addrs[r[30:28] % 3'd6];
        w.data.raw = r4;
        wb_fwd <= w;
        hw_irq <= (r[31] && r2[1]) ? (8'h01 << r2[2:0]) : 8'h00;  // sparse irq lines.
        csr_raddr <= csr_addrs[addr_idx];
        addr_idx = (addr_idx + 1) % 6;
    endtask

    // ******************************
    // reference model
    // ******************************
    task automatic predict(output exc_pkg::ctrl_t c, output logic exc, output logic ertn,
                           output logic [`ECODE_W-1:0] ecode);
        logic                 ie;
        logic [`INT_BITS-1:0] lie;
        logic [`INT_BITS-1:0] is_bits;
        logic [31:0]          era;
        logic [31:0]          eentry;
        logic                 intp;
        ie      = m_ie;
        lie     = m_lie;
        is_bits = {2'b00, m_hw, m_sw};
        era     = m_era;
        eentry  = m_eentry;
        if (wb_fwd.en) begin
            case (wb_fwd.addr)
                `CSR_CRMD:   ie      = wb_fwd.data.raw[2];
                `CSR_ECFG:   lie     = {wb_fwd.data.raw[12:11], wb_fwd.data.raw[9:0]};
                `CSR_ESTAT:  is_bits = {wb_fwd.data.raw[12:11], wb_fwd.data.raw[9:0]};
                `CSR_ERA:    era     = wb_fwd.data.raw;
                `CSR_EENTRY: eentry  = wb_fwd.data.raw;
                default: ;
            endcase
        end
        intp  = ie && ((lie & is_bits) != '0);
        exc   = mem.valid && ((mem.exc_valid != '0) || intp);
        ertn  = mem.valid && mem.is_ertn && !exc;
        ecode = `ECODE_NOP;
        if (intp) begin
            ecode = `ECODE_INT;
        end else begin
            for (int i = `EXC_SLOTS - 1; i >= 0; i--) begin
                if (mem.exc_valid[i]) begin
                    ecode = mem.exc_cause[i];  // highest slot found first.
                    break;
                end
            end
        end
        if (pause_req.pause_id) c.pause = 7'b0000111;
        else if (pause_req.pause_dispatch) c.pause = 7'b0001111;
        else if (pause_req.pause_ex) c.pause = 7'b0011111;
        else if (pause_req.pause_mem || (mem.valid && mem.is_idle && !intp))
            c.pause = 7'b0111111;
        else c.pause = 7'b0000000;
        c.flush  = exc || ertn;
        c.new_pc = ertn ? era : eentry;
    endtask

    task automatic advance_model(input exc_pkg::ctrl_t c, input logic exc, input logic ertn,
                                 input logic [`ECODE_W-1:0] ecode);
        logic [1:0] plv;
        logic       ie;
        logic [1:0] pplv;
        logic       pie;
        plv  = m_plv;
        ie   = m_ie;
        pplv = m_pplv;
        pie  = m_pie;
        if (wb_fwd.en) begin
            case (wb_fwd.addr)
                `CSR_CRMD: begin
                    m_plv = wb_fwd.data.raw[1:0];
                    m_ie  = wb_fwd.data.raw[2];
                end
                `CSR_PRMD: begin
                    m_pplv = wb_fwd.data.raw[1:0];
                    m_pie  = wb_fwd.data.raw[2];
                end
                `CSR_ECFG:   m_lie    = {wb_fwd.data.raw[12:11], wb_fwd.data.raw[9:0]};
                `CSR_ESTAT:  m_sw     = wb_fwd.data.raw[1:0];
                `CSR_ERA:    m_era    = wb_fwd.data.raw;
                `CSR_EENTRY: m_eentry = wb_fwd.data.raw;
                default: ;
            endcase
        end
        if (exc) begin
            m_pplv  = plv;
            m_pie   = ie;
            m_plv   = 2'b00;
            m_ie    = 1'b0;
            m_era   = mem.pc;
            m_ecode = ecode;
        end else if (ertn) begin
            m_plv = pplv;
            m_ie  = pie;
        end
        m_hw = hw_irq;
        if (c.flush) m_pc = c.new_pc;
        else if (!c.pause[0]) m_pc = m_pc + 32'd4;
    endtask

    function automatic exc_pkg::csr_word_u expect_csr(input logic [`CSR_ADDR_W-1:0] addr);
        exc_pkg::csr_word_u w;
        w.raw = 32'h0;
        case (addr)
            `CSR_CRMD: w.raw[2:0] = {m_ie, m_plv};
            `CSR_PRMD: w.raw[2:0] = {m_pie, m_pplv};
            `CSR_ECFG: begin
                w.irq.hi_int = m_lie[11:10];
                w.irq.hw_int = m_lie[9:2];
                w.irq.sw_int = m_lie[1:0];
            end
            `CSR_ESTAT: begin
                w.irq.ecode  = m_ecode;
                w.irq.hw_int = m_hw;
                w.irq.sw_int = m_sw;
            end
            `CSR_ERA:    w.raw = m_era;
            `CSR_EENTRY: w.raw = m_eentry;
            default: ;
        endcase
        return w;
    endfunction

    // ******************************
    // compare tasks
    // ******************************
    task automatic check_ctrl(input exc_pkg::ctrl_t got, input exc_pkg::ctrl_t want);
        if (got.pause !== want.pause) begin
            $display("ERROR ctrl_o.pause got 0x%02h exp 0x%02h at %0t", got.pause, want.pause,
                     $time);
            ctrl_errs++;
        end
        if (got.flush !== want.flush) begin
            $display("ERROR ctrl_o.flush got 0x%h exp 0x%h at %0t", got.flush, want.flush, $time);
            ctrl_errs++;
        end
        if (got.new_pc !== want.new_pc) begin
            $display("ERROR ctrl_o.new_pc got 0x%08h exp 0x%08h at %0t", got.new_pc,
                     want.new_pc, $time);
            ctrl_errs++;
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR pc_o got 0x%08h exp 0x%08h at %0t", got, want, $time);
            pc_errs++;
        end
    endtask

    task automatic check_csr(input exc_pkg::csr_word_u got, input exc_pkg::csr_word_u want,
                             input logic [`CSR_ADDR_W-1:0] addr);
        if (got.raw !== want.raw) begin
            $display("ERROR csr_rdata_o[0x%03h] got 0x%08h exp 0x%08h at %0t", addr, got.raw,
                     want.raw, $time);
            csr_errs++;
        end
    endtask

    // outputs are settled by the falling edge.
    always @(negedge clk) begin
        if (reset_i !== 1'b0) begin
            {m_plv, m_ie, m_pplv, m_pie} = '0;
            {m_lie, m_sw, m_hw, m_ecode} = '0;
            m_era    = 32'h0;
            m_eentry = 32'h0;
            m_pc     = `RESET_PC;
        end else begin
            predict(e_ctrl, e_exc, e_ertn, e_ecode);
            check_ctrl(ctrl, e_ctrl);
            check_pc(pc, m_pc);
            check_csr(csr_rdata, expect_csr(csr_raddr), csr_raddr);
            if (e_exc) n_exc++;
            if (e_ertn) n_ertn++;
            advance_model(e_ctrl, e_exc, e_ertn, e_ecode);
        end
    end

    initial begin
        seed      = 32'he127;
        addr_idx  = 0;
        reset_i   = 1'b1;
        pause_req = '0;
        mem       = '0;
        wb_fwd    = '0;
        hw_irq    = '0;
        csr_raddr = `CSR_CRMD;
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        $display("cycles %0d exceptions %0d ertn %0d errors ctrl %0d pc %0d csr %0d",
                 NUM_CYCLES, n_exc, n_ertn, ctrl_errs, pc_errs, csr_errs);
        if (ctrl_errs + pc_errs + csr_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(2 * NUM_CYCLES * 8);
        $display("timeout: run did not finish within %0d time units", 2 * NUM_CYCLES * 8);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/exc_ctrl_top.sv */
`default_nettype none

`include "exc_params.svh"

module exc_ctrl_top (
    input  wire                      clk,
    input  wire                      reset_i,
    input  exc_pkg::pause_req_t      pause_req_i,
    input  exc_pkg::mem_ctrl_t       mem_i,
    input  exc_pkg::csr_write_t      wb_fwd_i,
    input  wire  [`HW_IRQ_W-1:0]     hw_irq_i,
    input  wire  [`CSR_ADDR_W-1:0]   csr_raddr_i,
    output exc_pkg::ctrl_t           ctrl_o,
    output logic [31:0]              pc_o,
    output logic [31:0]              csr_rdata_o
);

    exc_pkg::csr_view_t   csr_view;
    exc_pkg::exc_commit_t exc_commit;
    exc_pkg::ctrl_t       ctrl;

    // ******************************
    // csr storage
    // ******************************
    csr_regfile csr_regfile_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_fwd_i (wb_fwd_i),
        .commit_i (exc_commit),
        .hw_irq_i (hw_irq_i),
        .raddr_i  (csr_raddr_i),
        .view_o   (csr_view),
        .rdata_o  (csr_rdata_o)
    );

    // ******************************
    // exception and stall control
    // ******************************
    pipeline_ctrl pipeline_ctrl_i (
        .pause_req_i (pause_req_i),
        .mem_i       (mem_i),
        .wb_fwd_i    (wb_fwd_i),
        .csr_i       (csr_view),
        .ctrl_o      (ctrl),
        .commit_o    (exc_commit)
    );

    pc_gen pc_gen_i (
        .clk     (clk),
        .reset_i (reset_i),
        .ctrl_i  (ctrl),
        .pc_o    (pc_o)
    );

    assign ctrl_o = ctrl;  // same-cycle view for the pipeline.

endmodule

`default_nettype wire

/* verilog/pc_gen.sv */
`default_nettype none

`include "exc_params.svh"

module pc_gen (
    input  wire                clk,
    input  wire                reset_i,
    input  exc_pkg::ctrl_t     ctrl_i,
    output logic [31:0]        pc_o
);

    logic [31:0] pc_q;

    // ******************************
    // fetch pc register
    // ******************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `RESET_PC;
        end else if (ctrl_i.flush) begin
            pc_q <= ctrl_i.new_pc;  // redirect wins over stall.
        end else if (!ctrl_i.pause[0]) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

    // a stall anywhere downstream also holds the pc stage.
    a_pause_has_pc : assert property (@(posedge clk) disable iff (reset_i)
        (ctrl_i.pause != 7'b0) |-> ctrl_i.pause[0]);

endmodule

`default_nettype wire

/* verilog/pipeline_ctrl.sv */
`default_nettype none

`include "exc_params.svh"

module pipeline_ctrl (
    input  exc_pkg::pause_req_t  pause_req_i,
    input  exc_pkg::mem_ctrl_t   mem_i,
    input  exc_pkg::csr_write_t  wb_fwd_i,
    input  exc_pkg::csr_view_t   csr_i,
    output exc_pkg::ctrl_t       ctrl_o,
    output exc_pkg::exc_commit_t commit_o
);

    logic                 hit_crmd;
    logic                 hit_ecfg;
    logic                 hit_estat;
    logic                 hit_era;
    logic                 hit_eentry;

    logic                 crmd_ie_cur;
    logic [`INT_BITS-1:0] lie_cur;
    logic [`INT_BITS-1:0] is_cur;
    logic [`INT_BITS-1:0] wb_irq_bits;
    logic [31:0]          era_cur;
    logic [31:0]          eentry_cur;

    logic                 int_pending;
    logic                 exc_raise;
    logic                 ertn_take;
    logic                 idle_stall;
    logic [`ECODE_W-1:0]  ecode;
    logic [6:0]           pause_vec;

    // ******************************
    // wb-stage csr forwarding
    // ******************************
    assign hit_crmd   = wb_fwd_i.en && (wb_fwd_i.addr == `CSR_CRMD);
    assign hit_ecfg   = wb_fwd_i.en && (wb_fwd_i.addr == `CSR_ECFG);
    assign hit_estat  = wb_fwd_i.en && (wb_fwd_i.addr == `CSR_ESTAT);
    assign hit_era    = wb_fwd_i.en && (wb_fwd_i.addr == `CSR_ERA);
    assign hit_eentry = wb_fwd_i.en && (wb_fwd_i.addr == `CSR_EENTRY);

    assign wb_irq_bits = {wb_fwd_i.data.irq.hi_int, wb_fwd_i.data.irq.hw_int,
                          wb_fwd_i.data.irq.sw_int};

    assign crmd_ie_cur = hit_crmd   ? wb_fwd_i.data.raw[2] : csr_i.crmd_ie;  // ie is bit 2.
    assign lie_cur     = hit_ecfg   ? wb_irq_bits          : csr_i.ecfg_lie;
    assign is_cur      = hit_estat  ? wb_irq_bits          : csr_i.estat_is;
    assign era_cur     = hit_era    ? wb_fwd_i.data.raw    : csr_i.era;
    assign eentry_cur  = hit_eentry ? wb_fwd_i.data.raw    : csr_i.eentry;

    // ******************************
    // interrupt and exception select
    // ******************************
    assign int_pending = crmd_ie_cur && ((lie_cur & is_cur) != '0);
    assign exc_raise   = mem_i.valid && ((mem_i.exc_valid != '0) || int_pending);
    assign ertn_take   = mem_i.valid && mem_i.is_ertn && !exc_raise;

    always_comb begin
        ecode = `ECODE_NOP;
        if (exc_raise) begin
            for (int i = 0; i < `EXC_SLOTS; i++) begin
                if (mem_i.exc_valid[i]) begin
                    ecode = mem_i.exc_cause[i];  // later slot overrides.
                end
            end
            if (int_pending) begin
                ecode = `ECODE_INT;
            end
        end
    end

    assign commit_o.is_exception = exc_raise;
    assign commit_o.is_ertn      = ertn_take;
    assign commit_o.ecode        = ecode;
    assign commit_o.epc          = mem_i.pc;

    // ******************************
    // pause vector
    // ******************************
    assign idle_stall = mem_i.valid && mem_i.is_idle && !int_pending;

    always_comb begin
        if (pause_req_i.pause_id) begin
            pause_vec = 7'b0000111;
        end else if (pause_req_i.pause_dispatch) begin
            pause_vec = 7'b0001111;
        end else if (pause_req_i.pause_ex) begin
            pause_vec = 7'b0011111;
        end else if (pause_req_i.pause_mem || idle_stall) begin
            pause_vec = 7'b0111111;
        end else begin
            pause_vec = 7'b0000000;
        end

        // earlier stages always stall with later ones.
        a_pause_pattern : assert (pause_vec inside {7'b0000000, 7'b0000111,
            7'b0001111, 7'b0011111, 7'b0111111});
    end

    always_comb begin
        // no exception without an instruction in mem.
        a_exc_needs_valid : assert (!exc_raise || mem_i.valid);
    end

    assign ctrl_o.pause  = pause_vec;
    assign ctrl_o.flush  = exc_raise || ertn_take;
    assign ctrl_o.new_pc = ertn_take ? era_cur : eentry_cur;

endmodule

`default_nettype wire

/* verilog/csr_regfile.sv */
`default_nettype none

`include "exc_params.svh"

module csr_regfile (
    input  wire                      clk,
    input  wire                      reset_i,
    input  exc_pkg::csr_write_t      wb_fwd_i,
    input  exc_pkg::exc_commit_t     commit_i,
    input  wire  [`HW_IRQ_W-1:0]     hw_irq_i,
    input  wire  [`CSR_ADDR_W-1:0]   raddr_i,
    output exc_pkg::csr_view_t       view_o,
    output logic [31:0]              rdata_o
);

    logic [1:0]           crmd_plv_q;
    logic                 crmd_ie_q;
    logic [1:0]           prmd_pplv_q;
    logic                 prmd_pie_q;
    logic [`INT_BITS-1:0] ecfg_lie_q;
    logic [1:0]           estat_sw_q;
    logic [`HW_IRQ_W-1:0] estat_hw_q;
    logic [`ECODE_W-1:0]  estat_ecode_q;
    logic [31:0]          era_q;
    logic [31:0]          eentry_q;

    exc_pkg::csr_word_u   ecfg_word;
    exc_pkg::csr_word_u   estat_word;
    logic                 wr_hit;

    assign wr_hit = wb_fwd_i.en;

    // ******************************
    // state update
    // ******************************
    always_ff @(posedge clk) begin
        if (reset_i) begin
            crmd_plv_q    <= 2'b00;
            crmd_ie_q     <= 1'b0;
            prmd_pplv_q   <= 2'b00;
            prmd_pie_q    <= 1'b0;
            ecfg_lie_q    <= '0;
            estat_sw_q    <= 2'b00;
            estat_hw_q    <= '0;
            estat_ecode_q <= '0;
            era_q         <= 32'h0;
            eentry_q      <= 32'h0;
        end else begin
            estat_hw_q <= hw_irq_i;  // sampled every cycle.

            if (wr_hit) begin
                case (wb_fwd_i.addr)
                    `CSR_CRMD: begin
                        crmd_plv_q <= wb_fwd_i.data.raw[1:0];
                        crmd_ie_q  <= wb_fwd_i.data.raw[2];
                    end
                    `CSR_PRMD: begin
                        prmd_pplv_q <= wb_fwd_i.data.raw[1:0];
                        prmd_pie_q  <= wb_fwd_i.data.raw[2];
                    end
                    `CSR_ECFG: begin
                        ecfg_lie_q <= {wb_fwd_i.data.irq.hi_int,
                                       wb_fwd_i.data.irq.hw_int,
                                       wb_fwd_i.data.irq.sw_int};
                    end
                    `CSR_ESTAT:  estat_sw_q <= wb_fwd_i.data.irq.sw_int;  // only swi bits.
                    `CSR_ERA:    era_q      <= wb_fwd_i.data.raw;
                    `CSR_EENTRY: eentry_q   <= wb_fwd_i.data.raw;
                    default: ;
                endcase
            end

            // commit overrides a software write on its own fields.
            if (commit_i.is_exception) begin
                prmd_pplv_q   <= crmd_plv_q;
                prmd_pie_q    <= crmd_ie_q;
                crmd_plv_q    <= 2'b00;
                crmd_ie_q     <= 1'b0;
                era_q         <= commit_i.epc;
                estat_ecode_q <= commit_i.ecode;
            end else if (commit_i.is_ertn) begin
                crmd_plv_q <= prmd_pplv_q;
                crmd_ie_q  <= prmd_pie_q;
            end
        end
    end

    // ******************************
    // read side
    // ******************************
    always_comb begin
        ecfg_word            = '0;
        ecfg_word.irq.hi_int = ecfg_lie_q[11:10];
        ecfg_word.irq.hw_int = ecfg_lie_q[9:2];
        ecfg_word.irq.sw_int = ecfg_lie_q[1:0];

        estat_word            = '0;
        estat_word.irq.ecode  = estat_ecode_q;
        estat_word.irq.hw_int = estat_hw_q;
        estat_word.irq.sw_int = estat_sw_q;  // hi_int stays 0, no timer.
    end

    always_comb begin
        case (raddr_i)
            `CSR_CRMD:   rdata_o = {29'h0, crmd_ie_q, crmd_plv_q};
            `CSR_PRMD:   rdata_o = {29'h0, prmd_pie_q, prmd_pplv_q};
            `CSR_ECFG:   rdata_o = ecfg_word.raw;
            `CSR_ESTAT:  rdata_o = estat_word.raw;
            `CSR_ERA:    rdata_o = era_q;
            `CSR_EENTRY: rdata_o = eentry_q;
            default:     rdata_o = 32'h0;
        endcase
    end

    assign view_o.crmd_ie  = crmd_ie_q;
    assign view_o.ecfg_lie = ecfg_lie_q;
    assign view_o.estat_is = {estat_word.irq.hi_int, estat_word.irq.hw_int,
                              estat_word.irq.sw_int};
    assign view_o.era      = era_q;
    assign view_o.eentry   = eentry_q;

    // control block never commits both at once.
    a_commit_onehot : assert property (@(posedge clk) disable iff (reset_i)
        !(commit_i.is_exception && commit_i.is_ertn));

endmodule

`default_nettype wire

/* verilog/exc_pkg.sv */
`default_nettype none

`include "exc_params.svh"

package exc_pkg;

    // ecfg/estat layout, shared by both registers.
    typedef struct packed {
        logic [9:0]           rsv_hi;
        logic [`ECODE_W-1:0]  ecode;   // estat only.
        logic [2:0]           rsv_mid;
        logic [1:0]           hi_int;
        logic                 rsv_10;
        logic [`HW_IRQ_W-1:0] hw_int;
        logic [1:0]           sw_int;
    } irq_fields_t;

    typedef union packed {
        logic [31:0] raw;
        irq_fields_t irq;
    } csr_word_u;

    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] addr;
        csr_word_u              data;
    } csr_write_t;

    typedef struct packed {
        logic                                  valid;
        logic [31:0]                           pc;
        logic [`EXC_SLOTS-1:0]                 exc_valid;  // slot 5 wins.
        logic [`EXC_SLOTS-1:0][`ECODE_W-1:0]   exc_cause;
        logic                                  is_ertn;
        logic                                  is_idle;
    } mem_ctrl_t;

    typedef struct packed {
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_req_t;

    typedef struct packed {
        logic [6:0]  pause;    // bit 0 pc ... bit 6 wb.
        logic        flush;
        logic [31:0] new_pc;
    } ctrl_t;

    typedef struct packed {
        logic                 crmd_ie;
        logic [`INT_BITS-1:0] ecfg_lie;
        logic [`INT_BITS-1:0] estat_is;
        logic [31:0]          era;
        logic [31:0]          eentry;
    } csr_view_t;

    typedef struct packed {
        logic                is_exception;
        logic                is_ertn;
        logic [`ECODE_W-1:0] ecode;
        logic [31:0]         epc;
    } exc_commit_t;

endpackage

`default_nettype wire

/* verilog/exc_params.svh */
`ifndef EXC_PARAMS_SVH
`define EXC_PARAMS_SVH

// ******************************
// csr addresses
// ******************************
`define CSR_ADDR_W  14
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_EENTRY  14'h00c

// ******************************
// exception codes
// ******************************
`define ECODE_W     6
`define ECODE_INT   6'h00
`define ECODE_NOP   6'h3f
`define EXC_SLOTS   6

// ******************************
// misc widths and reset values
// ******************************
`define RESET_PC    32'h1c000000
`define INT_BITS    12
`define HW_IRQ_W    8

`endif
